// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module sd_tb \
    -f sliding_detect.f -o sd_sim \
    && ./obj_dir/sd_sim > sim.log 2>&1

cat sim.log 2>/dev/null
grep -q "^test passed$" sim.log \
    && echo "simulation PASSED" \
    || { echo "simulation FAILED"; exit 1; }

// ==== sliding_detect.f ====
+incdir+include
source/sd_format_pkg.sv
source/sd_bus_pkg.sv
source/channel_tap_regs.sv
source/sample_window.sv
source/sliding_detector.sv
source/error_corrector.sv
source/sd_top.sv
tb/sd_tb.sv

// ==== source/channel_tap_regs.sv ====
`timescale 1ns/10ps

module channel_tap_regs
    import sd_format_pkg::*;
    import sd_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        cfg_req,
    input  sd_tap_cfg_t cfg,
    output logic        cfg_ack,
    output sd_taps_t    taps
);

    typedef enum logic [1:0] {
        st_idle,
        st_write,
        st_wait_release
    } tap_state_t;

    tap_state_t state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            taps  <= '0;
        end else begin
            case (state)
                st_idle: begin
                    // cfg is stable while req is up, take it right away
                    if (cfg_req) begin
                        taps[cfg.idx] <= cfg.value;
                        state         <= st_write;
                    end
                end
                st_write: begin
                    if (cfg_req) begin
                        state <= st_wait_release;
                    end else begin
                        state <= st_idle;
                    end
                end
                st_wait_release: begin
                    if (!cfg_req) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // ack high from the write edge until req is seen low
    assign cfg_ack = (state != st_idle);

endmodule

// ==== source/error_corrector.sv ====
`timescale 1ns/10ps

module error_corrector
    import sd_format_pkg::*;
    import sd_bus_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         in_valid,
    input  sd_block_t    cur_blk,
    input  sd_decision_t decision,
    output logic         out_valid,
    output sd_out_t      out_blk
);

    blk_bits_t flip_cur;
    blk_bits_t flip_prev;
    blk_bits_t flip;

    // set once a block sits in the window, the first accept has no output
    logic primed;

    always_comb begin
        for (int i = 0; i < blk_width; i++) begin
            flip_cur[i]  = decision[i][hyp_flip_cur];
            flip_prev[i] = decision[i][hyp_flip_prev];
        end
    end

    // position i+1 asking for its predecessor lands on bit i
    // a request from position 0 falls off the block
    assign flip = flip_cur ^ (flip_prev >> 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            primed    <= 1'b0;
        end else begin
            out_valid <= in_valid && primed;
            if (in_valid) begin
                primed <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_blk.bits      <= cur_blk.bits ^ flip;
            out_blk.decisions <= decision;
        end
    end

endmodule

// ==== source/sample_window.sv ====
`timescale 1ns/10ps

module sample_window
    import sd_format_pkg::*;
    import sd_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    input  sd_block_t in_blk,
    output sd_block_t prev_blk,
    output sd_block_t cur_blk
);

    // two-deep shift of accepted blocks
    // the incoming block itself is the third one the detector sees
    always_ff @(posedge clk) begin
        if (rst) begin
            prev_blk <= '0;
            cur_blk  <= '0;
        end else if (in_valid) begin
            prev_blk <= cur_blk;
            cur_blk  <= in_blk;
        end
    end

endmodule

// ==== source/sd_bus_pkg.sv ====
package sd_bus_pkg;

    import sd_format_pkg::*;

    // one slicer block, hard bits plus equalizer error per symbol
    typedef struct packed {
        blk_bits_t                   bits;
        err_sample_t [blk_width-1:0] errs;
    } sd_block_t;

    // single tap write from the host
    typedef struct packed {
        tap_idx_t idx;
        tap_t     value;
    } sd_tap_cfg_t;

    typedef tap_t [num_taps-1:0] sd_taps_t;

    // one code per position of the current block
    typedef hyp_t [blk_width-1:0] sd_decision_t;

    typedef struct packed {
        blk_bits_t    bits;
        sd_decision_t decisions;
    } sd_out_t;

endpackage

// ==== source/sd_format_pkg.sv ====
package sd_format_pkg;

    // block and window geometry
    localparam int blk_width  = 8;
    localparam int seq_length = 3;
    localparam int num_taps   = seq_length + 1;
    localparam int num_hyp    = 4;

    localparam int err_bits = 8;
    localparam int tap_bits = 8;

    // widest operand of one squared term
    localparam int max_bits    = (err_bits > tap_bits + 1) ? err_bits : tap_bits + 1;
    localparam int metric_bits = 2 * max_bits + 4 + $clog2(seq_length);

    // injected term is +-2*tap, a window sample adds at most two of them
    localparam int inj_bits = tap_bits + 2;
    localparam int sum_bits = max_bits + 3;

    // samples one position's window can reach, from the current block on
    localparam int win_len = blk_width + seq_length - 1;

    // bit positions inside a decision code
    // 0 none, 1 flip this position, 2 flip the previous one, 3 both
    localparam int hyp_flip_cur  = 0;
    localparam int hyp_flip_prev = 1;

    typedef logic signed [err_bits-1:0]   err_sample_t;
    typedef logic signed [tap_bits-1:0]   tap_t;
    typedef logic [$clog2(num_taps)-1:0]  tap_idx_t;
    typedef logic [1:0]                   hyp_t;
    typedef logic [metric_bits-1:0]       metric_t;
    typedef logic [blk_width-1:0]         blk_bits_t;
    typedef logic signed [inj_bits-1:0]   inj_t;
    typedef logic signed [sum_bits-1:0]   sum_t;

endpackage

// ==== source/sd_top.sv ====
`timescale 1ns/10ps

module sd_top
    import sd_format_pkg::*;
    import sd_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    input  sd_block_t   in_blk,
    input  logic        cfg_req,
    input  sd_tap_cfg_t cfg,
    output logic        cfg_ack,
    output logic        out_valid,
    output sd_out_t     out_blk
);

    sd_taps_t     taps;
    sd_block_t    prev_blk;
    sd_block_t    cur_blk;
    sd_decision_t decision;

    channel_tap_regs u_taps (
        .clk     (clk),
        .rst     (rst),
        .cfg_req (cfg_req),
        .cfg     (cfg),
        .cfg_ack (cfg_ack),
        .taps    (taps)
    );

    sample_window u_window (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_blk   (in_blk),
        .prev_blk (prev_blk),
        .cur_blk  (cur_blk)
    );

    // incoming block gives the look-ahead samples
    sliding_detector u_detect (
        .prev_blk (prev_blk),
        .cur_blk  (cur_blk),
        .next_blk (in_blk),
        .taps     (taps),
        .decision (decision)
    );

    error_corrector u_correct (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .cur_blk   (cur_blk),
        .decision  (decision),
        .out_valid (out_valid),
        .out_blk   (out_blk)
    );

endmodule

// ==== source/sliding_detector.sv ====
`timescale 1ns/10ps

module sliding_detector
    import sd_format_pkg::*;
    import sd_bus_pkg::*;
(
    input  sd_block_t    prev_blk,
    input  sd_block_t    cur_blk,
    input  sd_block_t    next_blk,
    input  sd_taps_t     taps,
    output sd_decision_t decision
);

    // polarity of each flip source, index 0 is the last bit of prev_blk
    logic [blk_width:0] pol;

    err_sample_t win    [win_len];
    inj_t        inj    [blk_width+1][seq_length];
    metric_t     metric [blk_width][num_hyp];

    function automatic metric_t square(input sum_t d);
        logic signed [metric_bits-1:0] w;
        w = d;
        return w * w;
    endfunction

    assign pol = {cur_blk.bits, prev_blk.bits[blk_width-1]};

    // current block samples, then the head of the incoming block
    always_comb begin
        for (int k = 0; k < blk_width; k++) begin
            win[k] = cur_blk.errs[k];
        end
        for (int k = 0; k < seq_length - 1; k++) begin
            win[blk_width+k] = next_blk.errs[k];
        end
    end

    // flipping a one injects -2*tap, flipping a zero +2*tap
    always_comb begin
        for (int p = 0; p <= blk_width; p++) begin
            for (int k = 0; k < seq_length; k++) begin
                if (pol[p]) begin
                    inj[p][k] = inj_t'(-2 * taps[k]);
                end else begin
                    inj[p][k] = inj_t'(2 * taps[k]);
                end
            end
        end
    end

    // summed squared error of every hypothesis at every position
    always_comb begin
        sum_t term;
        for (int i = 0; i < blk_width; i++) begin
            for (int h = 0; h < num_hyp; h++) begin
                metric[i][h] = '0;
                for (int j = 0; j < seq_length; j++) begin
                    term = sum_t'(win[i+j]);
                    // a flip at i only shows up from sample i+1
                    if (h[hyp_flip_cur] && j > 0) begin
                        term = term + sum_t'(inj[i+1][j-1]);
                    end
                    if (h[hyp_flip_prev]) begin
                        term = term + sum_t'(inj[i][j]);
                    end
                    metric[i][h] = metric[i][h] + square(term);
                end
            end
        end
    end

    always_comb begin
        hyp_t best;
        for (int i = 0; i < blk_width; i++) begin
            best = '0;
            for (int h = 1; h < num_hyp; h++) begin
                // strict compare, lower code keeps a tie
                if (metric[i][best] > metric[i][h]) begin
                    best = hyp_t'(h);
                end
            end
            decision[i] = best;
        end
    end

endmodule

// ==== include/sd_ref_model.svh ====
`ifndef SD_REF_MODEL_SVH
`define SD_REF_MODEL_SVH

// detection and correction on plain integers
// the including scope imports sd_format_pkg and sd_bus_pkg

function automatic sd_decision_t ref_detect(input sd_block_t prev, input sd_block_t cur,
                                            input sd_block_t nxt, input sd_taps_t taps);
    int           e [3*blk_width];
    int           b [3*blk_width];
    longint       cost [num_hyp];
    int           q;
    int           f;
    int           k;
    int           v;
    int           best;
    sd_decision_t dec;
    for (int i = 0; i < blk_width; i++) begin
        e[i]             = int'(prev.errs[i]);
        e[blk_width+i]   = int'(cur.errs[i]);
        e[2*blk_width+i] = int'(nxt.errs[i]);
        b[i]             = int'(prev.bits[i]);
        b[blk_width+i]   = int'(cur.bits[i]);
        b[2*blk_width+i] = int'(nxt.bits[i]);
    end
    for (int i = 0; i < blk_width; i++) begin
        q = blk_width + i;
        for (int h = 0; h < num_hyp; h++) begin
            cost[h] = 0;
            for (int s = q; s < q + seq_length; s++) begin
                v = e[s];
                // code bit 0 flips bit q, bit 1 flips bit q-1
                for (int m = 0; m < 2; m++) begin
                    if (h[m]) begin
                        f = q - m;
                        // bit f disturbs sample f+1+k through tap k
                        k = s - f - 1;
                        if (k >= 0 && k < num_taps) begin
                            v += (b[f] != 0 ? -2 : 2) * int'(taps[k]);
                        end
                    end
                end
                cost[h] += longint'(v) * longint'(v);
            end
        end
        best = 0;
        for (int h = 1; h < num_hyp; h++) begin
            if (cost[h] < cost[best]) begin
                best = h;
            end
        end
        dec[i] = hyp_t'(best);
    end
    return dec;
endfunction

function automatic sd_out_t ref_correct(input sd_block_t cur, input sd_decision_t dec);
    sd_out_t o;
    o.bits      = cur.bits;
    o.decisions = dec;
    for (int i = 0; i < blk_width; i++) begin
        if (dec[i][hyp_flip_cur]) begin
            o.bits[i] = ~o.bits[i];
        end
        // position 0 points at a block that has already left
        if (i > 0 && dec[i][hyp_flip_prev]) begin
            o.bits[i-1] = ~o.bits[i-1];
        end
    end
    return o;
endfunction

`endif

// ==== tb/sd_tb.sv ====
`timescale 1ns/10ps

module sd_tb
    import sd_format_pkg::*;
    import sd_bus_pkg::*;
();

    `include "sd_ref_model.svh"

    localparam int zero_blocks  = 40;
    localparam int num_rounds   = 4;
    localparam int round_blocks = 120;
    localparam int max_gap      = 4;
    localparam int write_cycles = 6;
    localparam int total_blocks = zero_blocks + num_rounds * round_blocks;
    localparam int total_writes = num_rounds * num_taps;
    localparam int cycle_limit  =
        (total_blocks + total_writes * write_cycles) * (max_gap + 1) + 20;

    logic        clk;
    logic        rst;
    logic        in_valid;
    sd_block_t   in_blk;
    logic        cfg_req;
    sd_tap_cfg_t cfg;
    logic        cfg_ack;
    logic        out_valid;
    sd_out_t     out_blk;

    logic [31:0] lfsr;
    int          cycles;

    // model state tracking the DUT edge by edge
    sd_taps_t     m_taps;
    sd_block_t    m_prev;
    sd_block_t    m_cur;
    logic         m_primed;
    logic         exp_valid;
    logic         exp_ack;
    logic         armed;
    sd_out_t      exp_q [$];
    blk_bits_t    raw_q [$];
    bit           zero_q [$];
    int           n_acc;
    int           n_out;
    int           code_seen [num_hyp];

    sd_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_blk    (in_blk),
        .cfg_req   (cfg_req),
        .cfg       (cfg),
        .cfg_ack   (cfg_ack),
        .out_valid (out_valid),
        .out_blk   (out_blk)
    );

    always #50 clk = ~clk;

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        abort_run($sformatf("CHECK FAILED %s expected 0x%0h got 0x%0h", name, exp, act));
    endtask

    // fibonacci lfsr for x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic sd_block_t random_block();
        sd_block_t         b;
        logic signed [5:0] e6;
        b.bits = blk_bits_t'(take_bits(blk_width));
        for (int i = 0; i < blk_width; i++) begin
            // errors near tap size so every hypothesis gets a chance
            e6        = 6'(take_bits(6));
            b.errs[i] = err_sample_t'(e6);
        end
        return b;
    endfunction

    task automatic send_block();
        int gap;
        gap = 0;
        if (take_bits(2) == 0) begin
            gap = int'(take_bits(2)) + 1;
        end
        if (gap > 0) begin
            in_valid <= 1'b0;
            repeat (gap) @(posedge clk);
        end
        in_valid <= 1'b1;
        in_blk   <= random_block();
        n_acc++;
        @(posedge clk);
    endtask

    // four-phase write that returns once ack is low again
    task automatic write_tap(input tap_idx_t idx, input tap_t value);
        in_valid  <= 1'b0;
        cfg.idx   <= idx;
        cfg.value <= value;
        cfg_req   <= 1'b1;
        do @(posedge clk); while (cfg_ack !== 1'b1);
        cfg_req <= 1'b0;
        do @(posedge clk); while (cfg_ack !== 1'b0);
    endtask

    task automatic load_random_taps();
        logic signed [4:0] t5;
        for (int i = 0; i < num_taps; i++) begin
            t5 = 5'(take_bits(5));
            write_tap(tap_idx_t'(i), tap_t'(t5));
        end
    endtask

    // outputs seen here were set up by the previous edge
    task automatic check_outputs();
        sd_out_t   exp;
        blk_bits_t raw;
        bit        zero;
        assert (cfg_ack === exp_ack)
            else report_mismatch("cfg_ack", 64'(exp_ack), 64'(cfg_ack));
        assert (out_valid === exp_valid)
            else report_mismatch("out_valid", 64'(exp_valid), 64'(out_valid));
        if (out_valid === 1'b1) begin
            exp  = exp_q.pop_front();
            raw  = raw_q.pop_front();
            zero = zero_q.pop_front();
            n_out++;
            assert (out_blk.decisions === exp.decisions)
                else report_mismatch("out_blk.decisions", 64'(exp.decisions),
                                     64'(out_blk.decisions));
            assert (out_blk.bits === exp.bits)
                else report_mismatch("out_blk.bits", 64'(exp.bits), 64'(out_blk.bits));
            if (zero) begin
                // all four sums tie so nothing may change
                assert (out_blk.decisions === '0)
                    else report_mismatch("out_blk.decisions", 64'(0),
                                         64'(out_blk.decisions));
                assert (out_blk.bits === raw)
                    else report_mismatch("out_blk.bits", 64'(raw), 64'(out_blk.bits));
            end
            for (int i = 0; i < blk_width; i++) begin
                code_seen[exp.decisions[i]]++;
            end
        end
    endtask

    task automatic step_model();
        sd_decision_t dec;
        if (in_valid) begin
            if (m_primed) begin
                dec = ref_detect(m_prev, m_cur, in_blk, m_taps);
                exp_q.push_back(ref_correct(m_cur, dec));
                raw_q.push_back(m_cur.bits);
                zero_q.push_back(m_taps == '0);
            end
            m_prev = m_cur;
            m_cur  = in_blk;
        end
        exp_valid = in_valid && m_primed;
        if (in_valid) begin
            m_primed = 1'b1;
        end
        // a write on this edge counts from the next accepted block
        if (cfg_req && !exp_ack) begin
            m_taps[cfg.idx] = cfg.value;
        end
        exp_ack = cfg_req;
    endtask

    always @(posedge clk) begin
        if (armed) begin
            check_outputs();
        end
        if (rst) begin
            m_taps    = '0;
            m_prev    = '0;
            m_cur     = '0;
            m_primed  = 1'b0;
            exp_valid = 1'b0;
            exp_ack   = 1'b0;
            armed     = 1'b1;
        end else begin
            step_model();
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            abort_run("timeout, the run did not finish within the cycle limit");
        end
    end

    initial begin
        lfsr     = 32'h1252_f38a;
        cycles   = 0;
        armed    = 1'b0;
        n_acc    = 0;
        n_out    = 0;
        clk      = 1'b0;
        rst      = 1'b1;
        in_valid = 1'b0;
        in_blk   = '0;
        cfg_req  = 1'b0;
        cfg      = '0;
        for (int h = 0; h < num_hyp; h++) begin
            code_seen[h] = 0;
        end

        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // taps still zero from reset
        repeat (zero_blocks) send_block();

        // each round rewrites the taps between blocks
        for (int r = 0; r < num_rounds; r++) begin
            load_random_taps();
            repeat (round_blocks) send_block();
        end
        in_valid <= 1'b0;
        repeat (3) @(posedge clk);

        assert (exp_q.size() == 0)
            else abort_run("a predicted output block never appeared");
        assert (n_out == n_acc - 1)
            else abort_run("output count is not the accepted block count minus one");
        assert (code_seen[1] > 0 && code_seen[2] > 0 && code_seen[3] > 0)
            else abort_run("random traffic did not produce every flip code");
        $display("test passed");
        $finish;
    end

endmodule
